// File: vgfx_trace.txt
# Columns: op, address or index (hex), data or expected value (hex)
# T test number, W host write, R host read, F fetch word, P pixel lookup
T 1 0
W 00040 11
W 00041 22
W 00042 33
W 00043 44
R 00040 11
R 00041 22
R 00042 33
R 00043 44
F 0010 44332211
T 2 0
W 00104 5a
W 0c105 7e
W 00106 96
W 00107 c3
R 04104 5a
R 00105 7e
R 38106 96
R e8107 c3
F 1041 c3967e5a
T 3 0
W f104a bc
W f104b 9a
W f11fe 21
W f11ff f3
R f104a bc
R f104b 9a
R f11fe 21
R f11ff f3
P 25 abc
P ff 321
T 4 0
W f2000 55
W ff04a 77
W f0040 ee
R f2000 00
R f7123 00
R f104a bc
R 00040 11
P 25 abc
T 5 0
F 0010 44332211
F 0041 c3967e5a
F 1010 44332211
F f041 c3967e5a
F 0010 44332211
R 04043 44
R 00106 96

// File: files.f
vgfx_pkg.sv
mem_req_if.sv
byte_lane_ram.sv
mem_arbiter.sv
host_decoder.sv
palette_unit.sv
vgfx_top.sv
vgfx_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module vgfx_tb -f files.f -o vgfx_sim
output=$(./obj_dir/vgfx_sim)
echo "$output"
if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// File: vgfx_tb.sv
module vgfx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                clk = 1'b0;
    logic                reset;

    logic                host_valid_i;
    logic                host_ready_o;
    logic                host_write_i;
    logic [19:0]         host_addr_i;
    logic [7:0]          host_wrdata_i;
    logic                host_resp_valid_o;
    logic [7:0]          host_rddata_o;

    logic                fetch_valid_i;
    logic                fetch_ready_o;
    logic [15:0]         fetch_addr_i;
    logic                fetch_rdvalid_o;
    logic [31:0]         fetch_rddata_o;

    logic                pix_valid_i;
    logic [7:0]          pix_index_i;
    logic                rgb_valid_o;
    logic [11:0]         rgb_o;

    // Trace contents, one entry per operation line
    logic [7:0]          op_kind[$];
    logic [31:0]         op_addr[$];
    logic [31:0]         op_data[$];
    bit                  trace_loaded = 1'b0;

    logic [31:0]         rng = 32'h1ef8_cf7a;
    int                  errors = 0;
    int                  checks = 0;
    int                  tests = 0;
    int                  test_errors = 0;
    int                  test_checks = 0;
    int                  cur_test = 0;

    vgfx_top uut (
        .clk               (clk),
        .reset             (reset),
        .host_valid_i      (host_valid_i),
        .host_ready_o      (host_ready_o),
        .host_write_i      (host_write_i),
        .host_addr_i       (host_addr_i),
        .host_wrdata_i     (host_wrdata_i),
        .host_resp_valid_o (host_resp_valid_o),
        .host_rddata_o     (host_rddata_o),
        .fetch_valid_i     (fetch_valid_i),
        .fetch_ready_o     (fetch_ready_o),
        .fetch_addr_i      (fetch_addr_i),
        .fetch_rdvalid_o   (fetch_rdvalid_o),
        .fetch_rddata_o    (fetch_rddata_o),
        .pix_valid_i       (pix_valid_i),
        .pix_index_i       (pix_index_i),
        .rgb_valid_o       (rgb_valid_o),
        .rgb_o             (rgb_o)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0d ns %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("Test %0d passed, %0d checks", cur_test, test_checks);
        end else begin
            $display("Test %0d FAILED, %0d of %0d checks wrong", cur_test, test_errors,
                     test_checks);
        end
        tests++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // Random display fetch traffic that competes with the host
    task automatic drive_background(output logic busy);
        rng = xorshift(rng);
        busy = rng[0];
        fetch_valid_i <= rng[0];
        fetch_addr_i  <= rng[31:16];
    endtask

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        ok = 1'b0;
        fd = $fopen("vgfx_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h", kind, a, d);
                    if (n == 3) begin
                        op_kind.push_back(kind);
                        op_addr.push_back(a);
                        op_data.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
        trace_loaded = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Port sequences
    ////////////////////////////////////////////////////////////////////

    task automatic host_op(input logic wr, input logic [19:0] addr, input logic [7:0] value);
        int         lat;
        int         exp_lat;
        logic       busy;
        logic [7:0] exp_data;
        exp_data = wr ? 8'h00 : value;
        // Register space answers at a fixed latency, main RAM waits for a free cycle
        exp_lat = 0;
        if (addr[19:16] == vgfx_pkg::REG_SPACE_TAG) begin
            exp_lat = (addr[15:12] == vgfx_pkg::PALETTE_BLOCK) ? 2 : 1;
        end
        @(negedge clk);
        while (!host_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        host_valid_i  <= 1'b1;
        host_write_i  <= wr;
        host_addr_i   <= addr;
        host_wrdata_i <= wr ? value : 8'h00;
        drive_background(busy);
        // Acceptance edge
        @(posedge clk);
        host_valid_i <= 1'b0;
        drive_background(busy);
        lat = 1;
        if (exp_lat == 0 && !busy) begin
            exp_lat = lat + 1;
        end
        @(negedge clk);
        compare_value("host_ready_o", 0, 32'(host_ready_o));
        while (!host_resp_valid_o) begin
            @(posedge clk);
            drive_background(busy);
            lat++;
            if (exp_lat == 0 && !busy) begin
                exp_lat = lat + 1;
            end
            @(negedge clk);
        end
        compare_value("host latency", exp_lat, lat);
        compare_value("host_rddata_o", 32'(exp_data), 32'(host_rddata_o));
        @(posedge clk);
        fetch_valid_i <= 1'b0;
        @(negedge clk);
        compare_value("host_resp_valid_o", 0, 32'(host_resp_valid_o));
        compare_value("host_ready_o", 1, 32'(host_ready_o));
    endtask

    // Back to back fetches, one per cycle
    task automatic fetch_stream(input int first, input int count);
        int k;
        @(posedge clk);
        fetch_valid_i <= 1'b1;
        fetch_addr_i  <= op_addr[first][15:0];
        @(negedge clk);
        compare_value("fetch_ready_o", 1, 32'(fetch_ready_o));
        compare_value("fetch_rdvalid_o", 0, 32'(fetch_rdvalid_o));
        for (k = 0; k < count; k++) begin
            @(posedge clk);
            if (k + 1 < count) begin
                fetch_addr_i <= op_addr[first + k + 1][15:0];
            end else begin
                fetch_valid_i <= 1'b0;
            end
            @(negedge clk);
            compare_value("fetch_rdvalid_o", 1, 32'(fetch_rdvalid_o));
            compare_value("fetch_rddata_o", op_data[first + k], fetch_rddata_o);
        end
        @(negedge clk);
        compare_value("fetch_rdvalid_o", 0, 32'(fetch_rdvalid_o));
    endtask

    task automatic pixel_stream(input int first, input int count);
        int k;
        @(posedge clk);
        pix_valid_i <= 1'b1;
        pix_index_i <= op_addr[first][7:0];
        @(negedge clk);
        compare_value("rgb_valid_o", 0, 32'(rgb_valid_o));
        for (k = 0; k < count; k++) begin
            @(posedge clk);
            if (k + 1 < count) begin
                pix_index_i <= op_addr[first + k + 1][7:0];
            end else begin
                pix_valid_i <= 1'b0;
            end
            @(negedge clk);
            compare_value("rgb_valid_o", 1, 32'(rgb_valid_o));
            compare_value("rgb_o", op_data[first + k], 32'(rgb_o));
        end
        @(negedge clk);
        compare_value("rgb_valid_o", 0, 32'(rgb_valid_o));
    endtask

    task automatic run_trace();
        int i;
        int n;
        i = 0;
        while (i < op_kind.size()) begin
            n = 1;
            case (op_kind[i])
                "T": begin
                    report_test();
                    cur_test = int'(op_addr[i]);
                end
                "W": begin
                    host_op(1'b1, op_addr[i][19:0], op_data[i][7:0]);
                end
                "R": begin
                    host_op(1'b0, op_addr[i][19:0], op_data[i][7:0]);
                end
                "F": begin
                    while (i + n < op_kind.size() && op_kind[i + n] == "F") begin
                        n++;
                    end
                    fetch_stream(i, n);
                end
                "P": begin
                    while (i + n < op_kind.size() && op_kind[i + n] == "P") begin
                        n++;
                    end
                    pixel_stream(i, n);
                end
                default: begin
                    $display("Trace entry %0d has an unknown operation", i);
                    errors++;
                    test_errors++;
                end
            endcase
            i += n;
        end
        report_test();
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////

    initial begin
        bit ok;
        reset         = 1'b1;
        host_valid_i  = 1'b0;
        host_write_i  = 1'b0;
        host_addr_i   = '0;
        host_wrdata_i = '0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        pix_valid_i   = 1'b0;
        pix_index_i   = '0;
        load_trace(ok);
        if (!ok) begin
            $display("Trace file vgfx_trace.txt could not be opened");
            $display("Done: errors found");
            $finish;
        end else begin
            repeat (8) @(posedge clk);
            reset <= 1'b0;
            // Test 0 covers the idle state after reset
            @(negedge clk);
            compare_value("host_ready_o", 1, 32'(host_ready_o));
            compare_value("host_resp_valid_o", 0, 32'(host_resp_valid_o));
            compare_value("fetch_rdvalid_o", 0, 32'(fetch_rdvalid_o));
            compare_value("rgb_valid_o", 0, 32'(rgb_valid_o));
            run_trace();
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

    // 200 cycles for each trace line, plus the reset phase
    initial begin
        wait (trace_loaded);
        repeat (op_kind.size() * 200 + 16) @(posedge clk);
        $display("Watchdog expired, the run did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: vgfx_top.sv
module vgfx_top (
    input  logic                              clk,
    input  logic                              reset,

    // Host port
    input  logic                              host_valid_i,
    output logic                              host_ready_o,
    input  logic                              host_write_i,
    input  logic [vgfx_pkg::HOST_ADDR_W-1:0]  host_addr_i,
    input  vgfx_pkg::byte_t                   host_wrdata_i,
    output logic                              host_resp_valid_o,
    output vgfx_pkg::byte_t                   host_rddata_o,

    // Display fetch port
    input  logic                              fetch_valid_i,
    output logic                              fetch_ready_o,
    input  logic [vgfx_pkg::FETCH_ADDR_W-1:0] fetch_addr_i,
    output logic                              fetch_rdvalid_o,
    output vgfx_pkg::mem_word_t               fetch_rddata_o,

    // Pixel lookup port
    input  logic                              pix_valid_i,
    input  vgfx_pkg::byte_t                   pix_index_i,
    output logic                              rgb_valid_o,
    output vgfx_pkg::rgb_t                    rgb_o
);

    mem_req_if fetch_if ();
    mem_req_if host_if ();

    logic                host_mem_rdvalid;
    vgfx_pkg::mem_word_t mem_rddata;

    logic                pal_wr_en;
    logic [8:0]          pal_addr;
    vgfx_pkg::byte_t     pal_wrdata;
    vgfx_pkg::byte_t     pal_rddata;

    //////////////////////////////////////////////////////////////////////
    // Fetch requester, read only
    //////////////////////////////////////////////////////////////////////

    assign fetch_if.valid   = fetch_valid_i;
    assign fetch_if.write   = 1'b0;
    assign fetch_if.addr    = fetch_addr_i;
    assign fetch_if.wrdata  = '0;
    assign fetch_if.bytesel = '0;
    assign fetch_ready_o    = fetch_if.ready;

    assign fetch_rddata_o = mem_rddata;

    //////////////////////////////////////////////////////////////////////
    // Host decode, main RAM and palette
    //////////////////////////////////////////////////////////////////////

    host_decoder host_decoder (
        .clk               (clk),
        .reset             (reset),
        .host_valid_i      (host_valid_i),
        .host_write_i      (host_write_i),
        .host_addr_i       (host_addr_i),
        .host_wrdata_i     (host_wrdata_i),
        .host_ready_o      (host_ready_o),
        .host_resp_valid_o (host_resp_valid_o),
        .host_rddata_o     (host_rddata_o),
        .mem_req           (host_if.requester),
        .mem_rdvalid_i     (host_mem_rdvalid),
        .mem_rddata_i      (mem_rddata),
        .pal_wr_en_o       (pal_wr_en),
        .pal_addr_o        (pal_addr),
        .pal_wrdata_o      (pal_wrdata),
        .pal_rddata_i      (pal_rddata)
    );

    mem_arbiter mem_arbiter (
        .clk             (clk),
        .reset           (reset),
        .fetch_req       (fetch_if.arbiter),
        .host_req        (host_if.arbiter),
        .fetch_rdvalid_o (fetch_rdvalid_o),
        .host_rdvalid_o  (host_mem_rdvalid),
        .rd_data_o       (mem_rddata)
    );

    palette_unit palette_unit (
        .clk         (clk),
        .wr_en_i     (pal_wr_en),
        .addr_i      (pal_addr),
        .wrdata_i    (pal_wrdata),
        .rddata_o    (pal_rddata),
        .pix_valid_i (pix_valid_i),
        .pix_index_i (pix_index_i),
        .rgb_valid_o (rgb_valid_o),
        .rgb_o       (rgb_o)
    );

endmodule

// File: palette_unit.sv
module palette_unit (
    input  logic                clk,

    // Host byte access
    input  logic                wr_en_i,
    input  logic [8:0]          addr_i,
    input  vgfx_pkg::byte_t     wrdata_i,
    output vgfx_pkg::byte_t     rddata_o,

    // Pixel lookup
    input  logic                pix_valid_i,
    input  vgfx_pkg::byte_t     pix_index_i,
    output logic                rgb_valid_o,
    output vgfx_pkg::rgb_t      rgb_o
);

    logic [1:0]          wr_lanes;
    vgfx_pkg::pal_word_t pix_word;
    vgfx_pkg::pal_word_t rb_word;
    logic                rb_high_q;

    // Bit 0 picks the byte, low byte first
    assign wr_lanes = addr_i[0] ? 2'b10 : 2'b01;

    //////////////////////////////////////////////////////////////////////
    // Display copy, read by pixel index
    //////////////////////////////////////////////////////////////////////

    byte_lane_ram #(
        .word_t (vgfx_pkg::pal_word_t),
        .DEPTH  (vgfx_pkg::PAL_ENTRIES)
    ) display_ram (
        .clk        (clk),
        .wr_en_i    (wr_en_i),
        .wr_addr_i  (addr_i[8:1]),
        .wr_lanes_i (wr_lanes),
        .wr_data_i  ({2{wrdata_i}}),
        .rd_addr_i  (pix_index_i),
        .rd_data_o  (pix_word)
    );

    always_ff @(posedge clk) begin
        rgb_valid_o <= pix_valid_i;
    end

    assign rgb_o = pix_word[11:0];

    //////////////////////////////////////////////////////////////////////
    // Readback copy, read by host address
    //////////////////////////////////////////////////////////////////////

    byte_lane_ram #(
        .word_t (vgfx_pkg::pal_word_t),
        .DEPTH  (vgfx_pkg::PAL_ENTRIES)
    ) readback_ram (
        .clk        (clk),
        .wr_en_i    (wr_en_i),
        .wr_addr_i  (addr_i[8:1]),
        .wr_lanes_i (wr_lanes),
        .wr_data_i  ({2{wrdata_i}}),
        .rd_addr_i  (addr_i[8:1]),
        .rd_data_o  (rb_word)
    );

    // Byte choice follows the word it belongs to
    always_ff @(posedge clk) begin
        rb_high_q <= addr_i[0];
    end

    assign rddata_o = rb_high_q ? rb_word[15:8] : rb_word[7:0];

endmodule

// File: host_decoder.sv
module host_decoder (
    input  logic                             clk,
    input  logic                             reset,

    // Host port
    input  logic                             host_valid_i,
    input  logic                             host_write_i,
    input  logic [vgfx_pkg::HOST_ADDR_W-1:0] host_addr_i,
    input  vgfx_pkg::byte_t                  host_wrdata_i,
    output logic                             host_ready_o,
    output logic                             host_resp_valid_o,
    output vgfx_pkg::byte_t                  host_rddata_o,

    // Main RAM requester
    mem_req_if.requester                     mem_req,
    input  logic                             mem_rdvalid_i,
    input  vgfx_pkg::mem_word_t              mem_rddata_i,

    // Palette
    output logic                             pal_wr_en_o,
    output logic [8:0]                       pal_addr_o,
    output vgfx_pkg::byte_t                  pal_wrdata_o,
    input  vgfx_pkg::byte_t                  pal_rddata_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_PAL,
        S_MEM
    } state_t;

    state_t                           state_q;
    logic                             accept;

    // Pending request
    logic                             req_write_q;
    logic [vgfx_pkg::HOST_ADDR_W-1:0] req_addr_q;
    vgfx_pkg::byte_t                  req_data_q;

    logic                             is_reg;
    logic                             is_pal;
    logic                             is_main;

    //////////////////////////////////////////////////////////////////////
    // Request capture and decode
    //////////////////////////////////////////////////////////////////////

    assign host_ready_o = (state_q == S_IDLE);
    assign accept       = host_valid_i && host_ready_o;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_write_q <= host_write_i;
            req_addr_q  <= host_addr_i;
            req_data_q  <= host_wrdata_i;
        end
    end

    assign is_reg  = (req_addr_q[19:16] == vgfx_pkg::REG_SPACE_TAG);
    assign is_pal  = is_reg && (req_addr_q[15:12] == vgfx_pkg::PALETTE_BLOCK);
    assign is_main = !is_reg;

    //////////////////////////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (is_pal) begin
                        state_q <= S_PAL;
                    end else if (is_main) begin
                        // Wait here while fetch holds the RAM
                        if (mem_req.ready) begin
                            state_q <= S_MEM;
                        end
                    end else begin
                        state_q <= S_IDLE;
                    end
                end
                S_PAL: begin
                    state_q <= S_IDLE;
                end
                S_MEM: begin
                    if (mem_rdvalid_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Unmapped blocks answer straight away
    assign host_resp_valid_o = (state_q == S_REQ && !is_pal && !is_main) ||
                               (state_q == S_PAL) ||
                               (state_q == S_MEM && mem_rdvalid_i);

    always_comb begin
        host_rddata_o = '0;
        if (!req_write_q) begin
            if (state_q == S_PAL) begin
                host_rddata_o = pal_rddata_i;
            end else if (state_q == S_MEM) begin
                host_rddata_o = mem_rddata_i[{req_addr_q[1:0], 3'b000} +: 8];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main RAM and palette requests
    //////////////////////////////////////////////////////////////////////

    // Byte on every lane, lane enable from the low address bits
    assign mem_req.valid   = (state_q == S_REQ) && is_main;
    assign mem_req.write   = req_write_q;
    assign mem_req.addr    = req_addr_q[17:2];
    assign mem_req.wrdata  = {4{req_data_q}};
    assign mem_req.bytesel = 4'b0001 << req_addr_q[1:0];

    assign pal_wr_en_o  = (state_q == S_REQ) && is_pal && req_write_q;
    assign pal_addr_o   = req_addr_q[8:0];
    assign pal_wrdata_o = req_data_q;

    // Pending request is not replaced before its response
    a_one_pending: assert property (
        @(posedge clk) disable iff (reset)
            (state_q != S_IDLE) |=> ($stable(req_addr_q) && $stable(req_write_q))
    );

endmodule

// File: mem_arbiter.sv
module mem_arbiter (
    input  logic                clk,
    input  logic                reset,

    // Requesters, fetch has the higher priority
    mem_req_if.arbiter          fetch_req,
    mem_req_if.arbiter          host_req,

    // Returning word and its owner
    output logic                fetch_rdvalid_o,
    output logic                host_rdvalid_o,
    output vgfx_pkg::mem_word_t rd_data_o
);

    logic                         grant_fetch;
    logic                         grant_host;

    logic                         ram_wr_en;
    logic [vgfx_pkg::MAIN_ADDR_W-1:0] ram_addr;
    logic [3:0]                   ram_lanes;
    vgfx_pkg::mem_word_t          ram_wrdata;

    //////////////////////////////////////////////////////////////////////
    // Fixed priority grant
    //////////////////////////////////////////////////////////////////////

    assign grant_fetch = fetch_req.valid;
    assign grant_host  = host_req.valid && !fetch_req.valid;

    // Fetch never waits, the host waits while fetch is active
    assign fetch_req.ready = 1'b1;
    assign host_req.ready  = !fetch_req.valid;

    //////////////////////////////////////////////////////////////////////
    // Main RAM port steering
    //////////////////////////////////////////////////////////////////////

    // Upper word address bits alias
    assign ram_addr   = grant_fetch ? fetch_req.addr[vgfx_pkg::MAIN_ADDR_W-1:0]
                                    : host_req.addr[vgfx_pkg::MAIN_ADDR_W-1:0];
    assign ram_wr_en  = grant_fetch ? fetch_req.write : (grant_host && host_req.write);
    assign ram_lanes  = grant_fetch ? fetch_req.bytesel : host_req.bytesel;
    assign ram_wrdata = grant_fetch ? fetch_req.wrdata : host_req.wrdata;

    byte_lane_ram #(
        .word_t (vgfx_pkg::mem_word_t),
        .DEPTH  (vgfx_pkg::MAIN_WORDS)
    ) main_ram (
        .clk        (clk),
        .wr_en_i    (ram_wr_en),
        .wr_addr_i  (ram_addr),
        .wr_lanes_i (ram_lanes),
        .wr_data_i  (ram_wrdata),
        .rd_addr_i  (ram_addr),
        .rd_data_o  (rd_data_o)
    );

    // Owner of the word leaving the RAM next cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_rdvalid_o <= 1'b0;
            host_rdvalid_o  <= 1'b0;
        end else begin
            fetch_rdvalid_o <= grant_fetch && !fetch_req.write;
            // Host writes also complete here
            host_rdvalid_o  <= grant_host;
        end
    end

    // A host transfer means the host alone owns the RAM port
    a_single_grant: assert property (
        @(posedge clk) disable iff (reset)
            (host_req.valid && host_req.ready) |-> (grant_host && !grant_fetch)
    );

endmodule

// File: byte_lane_ram.sv
module byte_lane_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 256
) (
    input  logic                         clk,

    // Write port
    input  logic                         wr_en_i,
    input  logic [$clog2(DEPTH)-1:0]     wr_addr_i,
    input  logic [$bits(word_t)/8-1:0]   wr_lanes_i,
    input  word_t                        wr_data_i,

    // Read port, one cycle latency
    input  logic [$clog2(DEPTH)-1:0]     rd_addr_i,
    output word_t                        rd_data_o
);

    word_t mem [DEPTH];

    // Only the selected byte lanes are updated
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int i = 0; i < $bits(word_t) / 8; i++) begin
                if (wr_lanes_i[i]) begin
                    mem[wr_addr_i][i*8 +: 8] <= wr_data_i[i*8 +: 8];
                end
            end
        end
    end

    // Old data on a read of the address being written
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    // A write with no lane selected means a broken byte select upstream
    a_write_has_lane: assert property (
        @(posedge clk) wr_en_i |-> (wr_lanes_i != '0)
    );

endmodule

// File: mem_req_if.sv
interface mem_req_if;

    // Handshake
    logic valid;
    logic ready;

    // Request fields, held by the requester while valid is high
    logic                              write;
    logic [vgfx_pkg::FETCH_ADDR_W-1:0] addr;
    vgfx_pkg::mem_word_t               wrdata;
    logic [3:0]                        bytesel;

    modport requester (
        output valid,
        output write,
        output addr,
        output wrdata,
        output bytesel,
        input  ready
    );

    modport arbiter (
        input  valid,
        input  write,
        input  addr,
        input  wrdata,
        input  bytesel,
        output ready
    );

endinterface

// File: vgfx_pkg.sv
package vgfx_pkg;

    //////////////////////////////////////////////////////////////////////
    // Host register bus
    //////////////////////////////////////////////////////////////////////

    // Byte-wide host address
    localparam int HOST_ADDR_W = 20;

    // Memory map, decoded on address bits 19:16 and 15:12
    //   00000-EFFFF  main RAM, aliased every MAIN_WORDS words
    //   F1000-F11FF  palette, two bytes per entry, low byte first
    //   Fx000        other register blocks read as zero
    localparam logic [3:0] REG_SPACE_TAG = 4'hF;
    localparam logic [3:0] PALETTE_BLOCK = 4'h1;

    //////////////////////////////////////////////////////////////////////
    // Main RAM
    //////////////////////////////////////////////////////////////////////

    localparam int MAIN_WORDS  = 4096;
    localparam int MAIN_ADDR_W = 12;

    // Word address as seen by the display fetch port
    localparam int FETCH_ADDR_W = 16;

    //////////////////////////////////////////////////////////////////////
    // Palette
    //////////////////////////////////////////////////////////////////////

    localparam int PAL_ENTRIES = 256;

    //////////////////////////////////////////////////////////////////////
    // Word types
    //////////////////////////////////////////////////////////////////////

    // Four byte lanes
    typedef logic [31:0] mem_word_t;

    // Two byte lanes, colour in the low 12 bits
    typedef logic [15:0] pal_word_t;

    // 4 bits each of R, G, B
    typedef logic [11:0] rgb_t;

    typedef logic [7:0] byte_t;

endpackage
